/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := exe_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation finished: PASS

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) verilog/exe_settings.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+verilog
verilog/exe_pkg.sv
verilog/iter_divider.sv
verilog/alu.sv
verilog/ex_stage.sv
verilog/data_ram.sv
verilog/mem_stage.sv
verilog/exe_top.sv
verification/exe_tb.sv

/* verification/exe_tb.sv */
`timescale 1ns/1ps

module exe_tb;
    localparam int NUM_VEC = 33;
    localparam int NUM_COL = 11;    // fields per vector line
    localparam int TIMEOUT = 200;

    typedef struct packed {
        logic [31:0]        idx;
        exe_pkg::word_t     pc;
        exe_pkg::word_t     wdata;
        logic               ale;
        logic               we;
        exe_pkg::reg_addr_t waddr;
        logic               cnt_low;    // low counter half, checked for growth only
    } expect_t;

    logic                clk = 1'b0;
    logic                resetn;
    logic                flush;
    logic                id_to_ex_valid;
    exe_pkg::id_to_ex_t  id_to_ex;
    logic                ex_allowin;
    logic                wb_allowin = 1'b1;
    logic                wb_valid;
    exe_pkg::mem_to_wb_t mem_to_wb;

    exe_pkg::word_t vec_mem [0:NUM_VEC*NUM_COL-1];
    expect_t        exp_q [$];
    integer         seed = 32'h8eb1;
    int             errors = 0;
    int             timeouts = 0;
    logic           have_cnt = 1'b0;
    exe_pkg::word_t last_cnt;

    exe_top i_exe_top (
        .clk            (clk),
        .resetn         (resetn),
        .flush          (flush),
        .id_to_ex_valid (id_to_ex_valid),
        .id_to_ex       (id_to_ex),
        .ex_allowin     (ex_allowin),
        .wb_allowin     (wb_allowin),
        .wb_valid       (wb_valid),
        .mem_to_wb      (mem_to_wb)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        #1 wb_allowin = ($random(seed) & 3) != 0;    // stall about one cycle in four
    end

    function automatic string test_name(int idx);
        exe_pkg::alu_op_e   op;
        exe_pkg::mem_kind_e kind;
        op   = exe_pkg::alu_op_e'(vec_mem[idx*NUM_COL + 1][3:0]);
        kind = exe_pkg::mem_kind_e'(vec_mem[idx*NUM_COL + 2][3:0]);
        return $sformatf("vec%0d_%s_%s", idx, op.name(), kind.name());
    endfunction

    task automatic check_writeback();
        expect_t exp;
        string   name;
        assert (exp_q.size() != 0) else begin
            errors++;
            $display("write-back of pc %h arrived with nothing outstanding", mem_to_wb.pc);
        end
        if (exp_q.size() != 0) begin
            exp  = exp_q.pop_front();
            name = test_name(exp.idx);
            assert (mem_to_wb.pc == exp.pc) else begin
                errors++;
                $display("[ERROR] %s pc expected %h actual %h", name, exp.pc, mem_to_wb.pc);
            end
            assert (mem_to_wb.excep_ale == exp.ale) else begin
                errors++;
                $display("[ERROR] %s excep_ale expected %b actual %b", name, exp.ale,
                         mem_to_wb.excep_ale);
            end
            assert (mem_to_wb.rf_we == exp.we) else begin
                errors++;
                $display("[ERROR] %s rf_we expected %b actual %b", name, exp.we,
                         mem_to_wb.rf_we);
            end
            assert (mem_to_wb.rf_waddr == exp.waddr) else begin
                errors++;
                $display("[ERROR] %s rf_waddr expected %h actual %h", name, exp.waddr,
                         mem_to_wb.rf_waddr);
            end
            if (exp.cnt_low) begin
                assert (!have_cnt || mem_to_wb.rf_wdata > last_cnt) else begin
                    errors++;
                    $display("[ERROR] %s rf_wdata expected above %h actual %h", name, last_cnt,
                             mem_to_wb.rf_wdata);
                end
                have_cnt = 1'b1;
                last_cnt = mem_to_wb.rf_wdata;
            end else begin
                assert (mem_to_wb.rf_wdata == exp.wdata) else begin
                    errors++;
                    $display("[ERROR] %s rf_wdata expected %h actual %h", name, exp.wdata,
                             mem_to_wb.rf_wdata);
                end
            end
        end
    endtask

    // handshake inputs are stable here, the transfer is on the next rising edge
    always @(negedge clk) begin
        if (resetn && wb_valid && wb_allowin) begin
            check_writeback();
        end
    end

    task automatic drive_vector(input int i, output logic ok);
        exe_pkg::id_to_ex_t b;
        expect_t            e;
        int                 n;
        b.pc           = 32'h1c00_0000 + 4 * i;
        b.alu_op       = exe_pkg::alu_op_e'(vec_mem[i*NUM_COL + 1][3:0]);
        b.mem_kind     = exe_pkg::mem_kind_e'(vec_mem[i*NUM_COL + 2][3:0]);
        b.src1         = vec_mem[i*NUM_COL + 3];
        b.src2         = vec_mem[i*NUM_COL + 4];
        b.rkd_value    = vec_mem[i*NUM_COL + 5];
        b.rf_waddr     = vec_mem[i*NUM_COL + 6][4:0];
        b.rf_we        = (b.rf_waddr != 5'd0);
        b.read_counter = vec_mem[i*NUM_COL + 7][0];
        b.counter_high = vec_mem[i*NUM_COL + 8][0];
        id_to_ex       = b;
        id_to_ex_valid = 1'b1;
        flush          = vec_mem[i*NUM_COL][0];
        n = 0;
        @(negedge clk);
        while (!ex_allowin && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ex_allowin) begin
            timeouts++;
            $display("timeout: ex_allowin stayed low for %0d cycles at vector %0d", TIMEOUT, i);
            ok = 1'b0;
            return;
        end
        if (!flush) begin
            e.idx     = i;
            e.pc      = b.pc;
            e.wdata   = vec_mem[i*NUM_COL + 9];
            e.ale     = vec_mem[i*NUM_COL + 10][0];
            e.we      = b.rf_we & ~e.ale;        // an ALE never writes the register file
            e.waddr   = b.rf_waddr;
            e.cnt_low = b.read_counter & ~b.counter_high;
            exp_q.push_back(e);
        end
        @(posedge clk);                // accepted on this edge
        #1;
        id_to_ex_valid = 1'b0;
        flush          = 1'b0;
        ok = 1'b1;
    endtask

    task automatic wait_drained(output logic ok);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = (exp_q.size() == 0);
        if (!ok) begin
            timeouts++;
            $display("timeout: %0d write-backs still missing after %0d cycles", exp_q.size(),
                     TIMEOUT);
        end
    endtask

    task automatic finish_run();
        $display("checks done: %0d errors, %0d timeouts, %0d write-backs missing", errors,
                 timeouts, exp_q.size());
        if (errors == 0 && timeouts == 0 && exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        logic ok;
        resetn         = 1'b0;
        flush          = 1'b0;
        id_to_ex_valid = 1'b0;
        id_to_ex       = '0;
        for (int k = 0; k < NUM_VEC*NUM_COL; k++) begin
            vec_mem[k] = ~k;           // far above any flag column value
        end
        $readmemh("verification/exe_vectors.hex", vec_mem);
        ok = 1'b1;
        if (vec_mem[NUM_VEC*NUM_COL - 1] > 32'd1) begin
            errors++;
            $display("vector file is missing or shorter than %0d lines", NUM_VEC);
            ok = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1 resetn = 1'b1;
        for (int i = 0; i < NUM_VEC && ok; i++) begin
            if (vec_mem[i*NUM_COL][0]) begin
                wait_drained(ok);       // flush must only hit its own line
                @(posedge clk);
                #1;
            end
            if (ok) begin
                drive_vector(i, ok);
            end
        end
        if (ok) begin
            wait_drained(ok);
        end
        finish_run();
    end

endmodule

/* verification/exe_vectors.hex */
// flush alu_op mem_kind src1 src2 rkd_value rf_waddr read_counter counter_high
// expected rf_wdata, expected excep_ale; load and store address is src1 + src2
0 0 0 7fffffff 00000001 00000000 01 0 0 80000000 0
0 1 0 00000005 00000007 00000000 02 0 0 fffffffe 0
0 2 0 fffffffe 00000003 00000000 03 0 0 00000001 0
0 3 0 fffffffe 00000003 00000000 04 0 0 00000000 0
0 4 0 f0f0f0f0 0ff00ff0 00000000 05 0 0 00f000f0 0
0 5 0 f0f0f0f0 0ff00ff0 00000000 06 0 0 fff0fff0 0
0 6 0 f0f0f0f0 0ff00ff0 00000000 07 0 0 ff00ff00 0
0 7 0 12340000 00005678 00000000 08 0 0 edcba987 0
0 8 0 80000001 00000001 00000000 09 0 0 00000002 0
0 9 0 80000000 00000004 00000000 0a 0 0 08000000 0
0 a 0 80000000 00000004 00000000 0b 0 0 f8000000 0
0 b 0 00000000 12345000 00000000 0c 0 0 12345000 0
0 c 0 fffffff9 00000002 00000000 0d 0 0 fffffffd 0
0 e 0 fffffff9 00000002 00000000 0e 0 0 ffffffff 0
0 d 0 fffffff9 00000002 00000000 0f 0 0 7ffffffc 0
0 f 0 fffffff9 00000002 00000000 10 0 0 00000001 0
0 c 0 00000064 00000000 00000000 11 0 0 ffffffff 0
0 e 0 00000064 00000000 00000000 12 0 0 00000064 0
0 0 8 00000100 00000000 11223344 00 0 0 00000100 0
0 0 6 00000100 00000001 000000aa 00 0 0 00000101 0
0 0 7 00000100 00000002 0000beef 00 0 0 00000102 0
0 0 3 00000100 00000000 00000000 13 0 0 beefaa44 0
0 0 1 00000100 00000001 00000000 14 0 0 ffffffaa 0
0 0 4 00000100 00000001 00000000 15 0 0 000000aa 0
0 0 2 00000100 00000002 00000000 16 0 0 ffffbeef 0
0 0 5 00000100 00000002 00000000 17 0 0 0000beef 0
0 0 2 00000100 00000001 00000000 18 0 0 00000000 1
0 0 8 00000100 00000002 deadbeef 00 0 0 00000102 1
1 0 8 00000100 00000000 cafef00d 00 0 0 00000100 0
0 0 3 00000100 00000000 00000000 19 0 0 beefaa44 0
0 0 0 00000000 00000000 00000000 1a 1 1 00000000 0
0 0 0 00000000 00000000 00000000 1b 1 0 00000000 0
0 0 0 00000000 00000000 00000000 1c 1 0 00000000 0

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic              clk,
    input  logic              resetn,
    input  exe_pkg::alu_op_e  alu_op,
    input  exe_pkg::word_t    src1,
    input  exe_pkg::word_t    src2,
    input  logic              op_valid,
    output exe_pkg::word_t    result,
    output logic              complete
);
    logic           is_div;
    logic           div_signed;
    logic           div_req;     // divide seen, start not sent yet
    logic           div_busy;    // divider still owned by the last start
    logic           div_start;
    logic           div_done;
    exe_pkg::word_t quotient;
    exe_pkg::word_t remainder;

    assign is_div = (alu_op == exe_pkg::alu_div) || (alu_op == exe_pkg::alu_divu) ||
                    (alu_op == exe_pkg::alu_mod) || (alu_op == exe_pkg::alu_modu);
    assign div_signed = (alu_op == exe_pkg::alu_div) || (alu_op == exe_pkg::alu_mod);
    assign div_start  = div_req & ~div_busy;   // one-cycle pulse, req drops with it

    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_req <= 1'b0;
        end else if (op_valid && is_div) begin
            div_req <= 1'b1;
        end else if (div_start) begin
            div_req <= 1'b0;
        end
    end

    // a flushed divide may still be running when the next one arrives
    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_busy <= 1'b0;
        end else if (div_start) begin
            div_busy <= 1'b1;
        end else if (div_done) begin
            div_busy <= 1'b0;
        end
    end

    iter_divider i_iter_divider (
        .clk       (clk),
        .resetn    (resetn),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (src1),
        .divisor   (src2),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (div_done)
    );

    // stale done from an older divide is masked until start goes out
    assign complete = is_div ? (div_done & ~op_valid & ~div_req) : 1'b1;

    always_comb begin
        case (alu_op)
            exe_pkg::alu_add:  result = src1 + src2;
            exe_pkg::alu_sub:  result = src1 - src2;
            exe_pkg::alu_slt:  result = {31'd0, $signed(src1) < $signed(src2)};
            exe_pkg::alu_sltu: result = {31'd0, src1 < src2};
            exe_pkg::alu_and:  result = src1 & src2;
            exe_pkg::alu_or:   result = src1 | src2;
            exe_pkg::alu_xor:  result = src1 ^ src2;
            exe_pkg::alu_nor:  result = ~(src1 | src2);
            exe_pkg::alu_sll:  result = src1 << src2[4:0];
            exe_pkg::alu_srl:  result = src1 >> src2[4:0];
            exe_pkg::alu_sra:  result = $signed(src1) >>> src2[4:0];
            exe_pkg::alu_lui:  result = src2;       // immediate comes in pre-shifted
            exe_pkg::alu_div,
            exe_pkg::alu_divu: result = quotient;
            default:           result = remainder;  // mod, modu
        endcase
    end

endmodule

/* verilog/data_ram.sv */
`timescale 1ns/1ps
`include "exe_settings.svh"

module data_ram (
    input  logic                   clk,
    input  logic                   en,
    input  logic [3:0]             we,
    input  logic [`EXE_RAM_AW-1:0] addr,
    input  exe_pkg::word_t         wdata,
    output exe_pkg::word_t         rdata
);
    exe_pkg::word_t mem [0:`EXE_RAM_WORDS-1];

    initial begin
        for (int i = 0; i < `EXE_RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];                       // old word, read before write
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* verilog/ex_stage.sv */
`timescale 1ns/1ps
`include "exe_settings.svh"

module ex_stage (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    flush,
    input  logic                    id_to_ex_valid,
    input  exe_pkg::id_to_ex_t      id_to_ex,
    output logic                    ex_allowin,
    input  logic                    mem_allowin,
    output logic                    ex_to_mem_valid,
    output exe_pkg::ex_to_mem_t     ex_to_mem,
    output logic                    data_sram_en,
    output logic [3:0]              data_sram_we,
    output logic [`EXE_RAM_AW-1:0]  data_sram_addr,
    output exe_pkg::word_t          data_sram_wdata
);
    logic               ex_valid;
    logic               alu_issue;     // first cycle of a new bundle
    exe_pkg::id_to_ex_t ex_bundle;
    logic [63:0]        stable_counter;
    exe_pkg::word_t     counter_snap;
    exe_pkg::word_t     alu_result;
    logic               alu_complete;
    logic               mem_fire;
    logic [1:0]         addr_low;
    logic               is_byte;
    logic               is_half;
    logic               is_word;
    logic               is_load;
    logic               is_store;
    logic               excep_ale;
    logic [3:0]         byte_we;

    assign ex_allowin      = ~ex_valid | alu_complete & mem_allowin;
    assign ex_to_mem_valid = ex_valid & alu_complete;
    assign mem_fire        = ex_to_mem_valid & mem_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid  <= 1'b0;
            alu_issue <= 1'b0;
        end else begin
            alu_issue <= id_to_ex_valid & ex_allowin & ~flush;
            if (flush) begin
                ex_valid <= 1'b0;              // drop held and incoming bundle
            end else if (ex_allowin) begin
                ex_valid <= id_to_ex_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (id_to_ex_valid && ex_allowin) begin
            ex_bundle    <= id_to_ex;
            counter_snap <= id_to_ex.counter_high ? stable_counter[63:32] : stable_counter[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stable_counter <= 64'd0;
        end else begin
            stable_counter <= stable_counter + 64'd1;
        end
    end

    alu i_alu (
        .clk      (clk),
        .resetn   (resetn),
        .alu_op   (ex_bundle.alu_op),
        .src1     (ex_bundle.src1),
        .src2     (ex_bundle.src2),
        .op_valid (alu_issue),
        .result   (alu_result),
        .complete (alu_complete)
    );

    assign addr_low = alu_result[1:0];
    assign is_byte  = (ex_bundle.mem_kind == exe_pkg::mem_ld_b) ||
                      (ex_bundle.mem_kind == exe_pkg::mem_ld_bu) ||
                      (ex_bundle.mem_kind == exe_pkg::mem_st_b);
    assign is_half  = (ex_bundle.mem_kind == exe_pkg::mem_ld_h) ||
                      (ex_bundle.mem_kind == exe_pkg::mem_ld_hu) ||
                      (ex_bundle.mem_kind == exe_pkg::mem_st_h);
    assign is_word  = (ex_bundle.mem_kind == exe_pkg::mem_ld_w) ||
                      (ex_bundle.mem_kind == exe_pkg::mem_st_w);
    assign is_store = (ex_bundle.mem_kind == exe_pkg::mem_st_b) ||
                      (ex_bundle.mem_kind == exe_pkg::mem_st_h) ||
                      (ex_bundle.mem_kind == exe_pkg::mem_st_w);
    assign is_load  = (is_byte | is_half | is_word) & ~is_store;

    assign excep_ale = (is_half & addr_low[0]) | (is_word & (addr_low != 2'b00));

    assign byte_we = is_byte ? (4'b0001 << addr_low) :
                     is_half ? (addr_low[1] ? 4'b1100 : 4'b0011) :
                               4'b1111;

    // memory is touched only on the transfer edge
    assign data_sram_en    = mem_fire & (is_load | is_store) & ~excep_ale;
    assign data_sram_we    = {4{mem_fire & is_store & ~excep_ale}} & byte_we;
    assign data_sram_addr  = alu_result[`EXE_RAM_AW+1:2];
    assign data_sram_wdata = is_byte ? {4{ex_bundle.rkd_value[7:0]}} :
                             is_half ? {2{ex_bundle.rkd_value[15:0]}} :
                                       ex_bundle.rkd_value;

    always_comb begin
        ex_to_mem.pc        = ex_bundle.pc;
        ex_to_mem.rf_we     = ex_bundle.rf_we & ~excep_ale;
        ex_to_mem.rf_waddr  = ex_bundle.rf_waddr;
        ex_to_mem.result    = ex_bundle.read_counter ? counter_snap : alu_result;
        ex_to_mem.mem_kind  = ex_bundle.mem_kind;
        ex_to_mem.addr_low  = addr_low;
        ex_to_mem.excep_ale = excep_ale;
    end

    we_needs_en: assert property (@(posedge clk) disable iff (!resetn)
        (data_sram_we != 4'b0000) |-> data_sram_en && mem_allowin)
        else $error("ex_stage: byte write without a memory request");

    hold_on_stall: assert property (@(posedge clk) disable iff (!resetn)
        ex_to_mem_valid && !mem_allowin && !flush |=> ex_to_mem_valid && $stable(ex_to_mem))
        else $error("ex_stage: bundle changed while mem_stage stalled");

endmodule

/* verilog/exe_pkg.sv */
package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_nor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11,
        alu_div  = 4'd12,
        alu_divu = 4'd13,
        alu_mod  = 4'd14,
        alu_modu = 4'd15
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none  = 4'd0,
        mem_ld_b  = 4'd1,
        mem_ld_h  = 4'd2,
        mem_ld_w  = 4'd3,
        mem_ld_bu = 4'd4,
        mem_ld_hu = 4'd5,
        mem_st_b  = 4'd6,
        mem_st_h  = 4'd7,
        mem_st_w  = 4'd8
    } mem_kind_e;

    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_done
    } div_state_e;

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        word_t     src1;
        word_t     src2;
        word_t     rkd_value;     // store data
        mem_kind_e mem_kind;
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      read_counter;
        logic      counter_high;  // high half of the stable counter
    } id_to_ex_t;

    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     result;        // alu result, counter half or address
        mem_kind_e mem_kind;
        logic [1:0] addr_low;
        logic      excep_ale;
    } ex_to_mem_t;

    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     rf_wdata;
        logic      excep_ale;
    } mem_to_wb_t;

endpackage

/* verilog/exe_settings.svh */
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// data memory geometry, one 32-bit word per entry

`define EXE_RAM_WORDS 256  // words in data_ram
`define EXE_RAM_AW    8    // word address width, log2 of EXE_RAM_WORDS

// byte address bits above the word offset map to addr[EXE_RAM_AW+1:2]
// upper address bits are ignored by the memory

`endif

/* verilog/exe_top.sv */
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                flush,
    input  logic                id_to_ex_valid,
    input  exe_pkg::id_to_ex_t  id_to_ex,
    output logic                ex_allowin,
    input  logic                wb_allowin,
    output logic                wb_valid,
    output exe_pkg::mem_to_wb_t mem_to_wb
);
    logic                    ex_to_mem_valid;
    exe_pkg::ex_to_mem_t     ex_to_mem;
    logic                    mem_allowin;
    logic                    data_sram_en;
    logic [3:0]              data_sram_we;
    logic [`EXE_RAM_AW-1:0]  data_sram_addr;
    exe_pkg::word_t          data_sram_wdata;
    exe_pkg::word_t          data_sram_rdata;

    ex_stage i_ex_stage (
        .clk (clk), .resetn (resetn), .flush (flush),
        .id_to_ex_valid (id_to_ex_valid), .id_to_ex (id_to_ex), .ex_allowin (ex_allowin),
        .mem_allowin (mem_allowin), .ex_to_mem_valid (ex_to_mem_valid), .ex_to_mem (ex_to_mem),
        .data_sram_en (data_sram_en), .data_sram_we (data_sram_we),
        .data_sram_addr (data_sram_addr), .data_sram_wdata (data_sram_wdata)
    );

    data_ram i_data_ram (
        .clk (clk), .en (data_sram_en), .we (data_sram_we), .addr (data_sram_addr),
        .wdata (data_sram_wdata), .rdata (data_sram_rdata)
    );

    mem_stage i_mem_stage (
        .clk (clk), .resetn (resetn),
        .ex_to_mem_valid (ex_to_mem_valid), .ex_to_mem (ex_to_mem), .mem_allowin (mem_allowin),
        .rdata (data_sram_rdata), .wb_allowin (wb_allowin),
        .wb_valid (wb_valid), .mem_to_wb (mem_to_wb)
    );

endmodule

/* verilog/iter_divider.sv */
`timescale 1ns/1ps

module iter_divider (
    input  logic           clk,
    input  logic           resetn,
    input  logic           start,
    input  logic           is_signed,
    input  exe_pkg::word_t dividend,
    input  exe_pkg::word_t divisor,
    output exe_pkg::word_t quotient,
    output exe_pkg::word_t remainder,
    output logic           done
);
    exe_pkg::div_state_e state;
    logic [4:0]     step;
    logic           load;
    exe_pkg::word_t rem_q;
    exe_pkg::word_t quo_q;    // dividend shifts out, quotient shifts in
    exe_pkg::word_t dsr_q;
    logic           neg_quo;
    logic           neg_rem;
    logic           by_zero;
    logic [32:0]    shifted;
    logic [32:0]    trial;

    assign load    = start & (state != exe_pkg::div_run);
    assign shifted = {rem_q, quo_q[31]};
    assign trial   = shifted - {1'b0, dsr_q};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= exe_pkg::div_idle;
            step  <= 5'd0;
        end else if (load) begin
            state <= exe_pkg::div_run;
            step  <= 5'd0;
        end else if (state == exe_pkg::div_run) begin
            step <= step + 5'd1;
            if (step == 5'd31) begin
                state <= exe_pkg::div_done;  // done held until next start
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rem_q   <= '0;
            quo_q   <= (is_signed && dividend[31]) ? -dividend : dividend;
            dsr_q   <= (is_signed && divisor[31]) ? -divisor : divisor;
            neg_quo <= is_signed && (dividend[31] ^ divisor[31]);
            neg_rem <= is_signed && dividend[31];   // remainder follows dividend sign
            by_zero <= (divisor == '0);
        end else if (state == exe_pkg::div_run) begin
            if (!trial[32]) begin
                rem_q <= trial[31:0];                // subtract fits
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= shifted[31:0];              // restore
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    assign quotient  = by_zero ? '1 : (neg_quo ? -quo_q : quo_q);
    assign remainder = neg_rem ? -rem_q : rem_q;
    assign done      = (state == exe_pkg::div_done);

    no_start_while_run: assert property (@(posedge clk) disable iff (!resetn)
        start |-> state != exe_pkg::div_run)
        else $error("iter_divider: start while a division is running");

endmodule

/* verilog/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 ex_to_mem_valid,
    input  exe_pkg::ex_to_mem_t  ex_to_mem,
    output logic                 mem_allowin,
    input  exe_pkg::word_t       rdata,
    input  logic                 wb_allowin,
    output logic                 wb_valid,
    output exe_pkg::mem_to_wb_t  mem_to_wb
);
    logic                mem_valid;
    exe_pkg::ex_to_mem_t mem_rec;
    logic [7:0]          ld_byte;
    logic [15:0]         ld_half;
    exe_pkg::word_t      wb_data;

    assign mem_allowin = ~mem_valid | wb_allowin;    // always ready to go
    assign wb_valid    = mem_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_to_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin) begin
            mem_rec <= ex_to_mem;
        end
    end

    // rdata arrives one cycle after the transfer and is held by the ram
    assign ld_byte = rdata[8*mem_rec.addr_low +: 8];
    assign ld_half = mem_rec.addr_low[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (mem_rec.mem_kind)
            exe_pkg::mem_ld_b:  wb_data = {{24{ld_byte[7]}}, ld_byte};
            exe_pkg::mem_ld_bu: wb_data = {24'd0, ld_byte};
            exe_pkg::mem_ld_h:  wb_data = {{16{ld_half[15]}}, ld_half};
            exe_pkg::mem_ld_hu: wb_data = {16'd0, ld_half};
            exe_pkg::mem_ld_w:  wb_data = rdata;
            default:            wb_data = mem_rec.result;
        endcase
        if (mem_rec.excep_ale && mem_rec.mem_kind inside {exe_pkg::mem_ld_b, exe_pkg::mem_ld_bu,
                exe_pkg::mem_ld_h, exe_pkg::mem_ld_hu, exe_pkg::mem_ld_w}) begin
            wb_data = '0;   // faulting load returns nothing
        end
    end

    always_comb begin
        mem_to_wb.pc        = mem_rec.pc;
        mem_to_wb.rf_we     = mem_rec.rf_we;
        mem_to_wb.rf_waddr  = mem_rec.rf_waddr;
        mem_to_wb.rf_wdata  = wb_data;
        mem_to_wb.excep_ale = mem_rec.excep_ale;
    end

    wb_hold: assert property (@(posedge clk) disable iff (!resetn)
        wb_valid && !wb_allowin |=> $stable(mem_to_wb))
        else $error("mem_stage: write-back record changed under back-pressure");

endmodule
